// File: src/div_pkg.sv
// Shared widths, operation codes and pipeline structs for the divide unit; compile first
`default_nettype none

package div_pkg;

    // --------------------
    // Widths and pipeline shape
    localparam int XLEN     = 64;
    localparam int WLEN     = XLEN / 2;   // Word operand width
    localparam int TAG_W    = 8;
    localparam int N_STAGES = 32;         // Two quotient bits per stage
    localparam int W_EXIT   = 16;         // Word ops leave here

    // Bit 2 marks word, bit 1 remainder, bit 0 unsigned
    typedef enum logic [2:0] {
        OP_DIV   = 3'b000,
        OP_DIVU  = 3'b001,
        OP_REM   = 3'b010,
        OP_REMU  = 3'b011,
        OP_DIVW  = 3'b100,
        OP_DIVUW = 3'b101,
        OP_REMW  = 3'b110,
        OP_REMUW = 3'b111
    } div_op_e;

    // --------------------
    // External request and response
    typedef struct packed {
        logic             valid;
        div_op_e          op;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  src1;   // Dividend
        logic [XLEN-1:0]  src2;   // Divisor
    } div_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  result;
    } div_resp_t;

    // --------------------
    // Per-stage control sideband
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic             is_word;
        logic             is_rem;
        logic             div_zero;
        logic             neg_quo;   // Operand signs differ
        logic             neg_rem;   // Dividend was negative
    } div_meta_t;

    // Per-stage datapath word
    typedef struct packed {
        logic [XLEN-1:0] rem;
        logic [XLEN-1:0] dq;        // Dividend bits shift out, quotient bits shift in
        logic [XLEN-1:0] divisor;
    } div_data_t;

endpackage

`default_nettype wire

// File: src/div_operand_prep.sv
// Turns a raw request into unsigned, aligned operands and the sign/zero flags for the pipeline
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
    input  div_pkg::div_req_t  req_i,
    output div_pkg::div_data_t data_o,
    output div_pkg::div_meta_t meta_o
);

    localparam int XLEN = div_pkg::XLEN;
    localparam int WLEN = div_pkg::WLEN;

    always_comb begin
        logic [2:0]      op;
        logic            is_word;
        logic            is_signed;
        logic            neg1;
        logic            neg2;
        logic [XLEN-1:0] mag1;
        logic [XLEN-1:0] mag2;

        op        = req_i.op;
        is_word   = op[2];
        is_signed = ~op[0];

        // Sign bit position depends on operand width
        neg1 = is_signed & (is_word ? req_i.src1[WLEN-1] : req_i.src1[XLEN-1]);
        neg2 = is_signed & (is_word ? req_i.src2[WLEN-1] : req_i.src2[XLEN-1]);

        mag1 = neg1 ? -req_i.src1 : req_i.src1;
        mag2 = neg2 ? -req_i.src2 : req_i.src2;

        data_o.rem     = '0;
        data_o.dq      = is_word ? {mag1[WLEN-1:0], {WLEN{1'b0}}} : mag1;   // Word in upper half
        data_o.divisor = is_word ? {{WLEN{1'b0}}, mag2[WLEN-1:0]} : mag2;

        meta_o.valid    = req_i.valid;
        meta_o.tag      = req_i.tag;
        meta_o.is_word  = is_word;
        meta_o.is_rem   = op[1];
        meta_o.div_zero = is_word ? (req_i.src2[WLEN-1:0] == '0) : (req_i.src2 == '0);
        meta_o.neg_quo  = neg1 ^ neg2;
        meta_o.neg_rem  = neg1;   // Remainder takes the dividend sign
    end

endmodule

`default_nettype wire

// File: src/div_stage.sv
// One radix-4 restoring division step: two shift/compare/subtract passes, purely combinational
`timescale 1ns/1ps
`default_nettype none

module div_stage (
    input  div_pkg::div_data_t data_i,
    output div_pkg::div_data_t data_o
);

    localparam int XLEN = div_pkg::XLEN;

    always_comb begin
        logic [XLEN:0] shifted;
        logic [XLEN:0] diff;

        data_o = data_i;
        for (int b = 0; b < 2; b++) begin
            // Extra bit covers divisors above 2^63
            shifted = {data_o.rem, data_o.dq[XLEN-1]};
            diff    = shifted - {1'b0, data_o.divisor};
            data_o.dq  = {data_o.dq[XLEN-2:0], ~diff[XLEN]};
            data_o.rem = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];   // Restore on borrow
        end
    end

endmodule

`default_nettype wire

// File: src/div_array.sv
// Registered chain of division stages; exposes the word exit and the final 64-bit exit
`timescale 1ns/1ps
`default_nettype none

module div_array #(
    parameter int N_STAGES = div_pkg::N_STAGES,
    parameter int W_EXIT   = div_pkg::W_EXIT
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  div_pkg::div_data_t data_i,
    output div_pkg::div_data_t w_data_o,
    output div_pkg::div_data_t d_data_o
);

    div_pkg::div_data_t data_q   [N_STAGES:0];
    div_pkg::div_data_t stage_out[N_STAGES:1];

    // --------------------
    // Combinational steps between registers
    genvar gi;
    generate
        for (gi = N_STAGES; gi >= 1; gi--) begin : g_stage
            div_stage u_stage (
                .data_i (data_q[gi]),
                .data_o (stage_out[gi])
            );
        end
    endgenerate

    // --------------------
    // Data registers, qualified by the control valid bits downstream
    always_ff @(posedge clk_i) begin
        if (rstn_i) begin   // Chain frozen while reset is held
            data_q[N_STAGES] <= data_i;
            for (int i = 0; i < N_STAGES; i++) begin
                data_q[i] <= stage_out[i+1];
            end
        end
    end

    assign w_data_o = data_q[W_EXIT];   // 32 quotient bits done
    assign d_data_o = data_q[0];        // 64 quotient bits done

endmodule

`default_nettype wire

// File: src/div_ctrl.sv
// Control pipeline for the divider: valid/sideband shift, kill flush, issue refusal, exit select
`timescale 1ns/1ps
`default_nettype none

module div_ctrl #(
    parameter int N_STAGES = div_pkg::N_STAGES,
    parameter int W_EXIT   = div_pkg::W_EXIT
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               kill_i,
    input  logic               req_valid_i,
    input  logic               req_word_i,
    input  div_pkg::div_meta_t meta_i,
    output logic               ready_o,
    output logic               exit_w_o,
    output div_pkg::div_meta_t meta_o
);

    div_pkg::div_meta_t meta_q[N_STAGES:0];
    logic               accept;

    // A 64-bit op one stage before the word exit would collide with a word op issued now
    assign ready_o = ~(req_word_i & meta_q[W_EXIT+1].valid & ~meta_q[W_EXIT+1].is_word);
    assign accept  = req_valid_i & ready_o & ~kill_i;

    // --------------------
    // Meta shift register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i <= N_STAGES; i++) begin
                meta_q[i] <= '0;
            end
        end else begin
            meta_q[N_STAGES]       <= meta_i;
            meta_q[N_STAGES].valid <= accept;
            for (int i = 0; i < N_STAGES; i++) begin
                meta_q[i]       <= meta_q[i+1];
                meta_q[i].valid <= meta_q[i+1].valid & ~kill_i;   // Flush in flight ops
            end
        end
    end

    // --------------------
    // Exit selection, at most one source per cycle
    assign exit_w_o = meta_q[W_EXIT].valid & meta_q[W_EXIT].is_word;

    always_comb begin
        if (exit_w_o) begin
            meta_o = meta_q[W_EXIT];
        end else begin
            meta_o       = meta_q[0];
            meta_o.valid = meta_q[0].valid & ~meta_q[0].is_word;   // Word ops already left
        end
    end

endmodule

`default_nettype wire

// File: src/div_result_fix.sv
// Final result correction: sign fixes, divide-by-zero quotient, quotient/remainder pick, word extension
`timescale 1ns/1ps
`default_nettype none

module div_result_fix (
    input  div_pkg::div_meta_t meta_i,
    input  logic               exit_w_i,
    input  div_pkg::div_data_t w_data_i,
    input  div_pkg::div_data_t d_data_i,
    output div_pkg::div_resp_t resp_o
);

    localparam int XLEN = div_pkg::XLEN;
    localparam int WLEN = div_pkg::WLEN;

    always_comb begin
        div_pkg::div_data_t data;
        logic [XLEN-1:0]    quo;
        logic [XLEN-1:0]    rmd;
        logic [XLEN-1:0]    res;

        data = exit_w_i ? w_data_i : d_data_i;

        quo = meta_i.neg_quo ? -data.dq : data.dq;
        if (meta_i.div_zero) begin
            quo = '1;   // RISC-V x/0 quotient
        end
        rmd = meta_i.neg_rem ? -data.rem : data.rem;

        res = meta_i.is_rem ? rmd : quo;

        resp_o.valid  = meta_i.valid;
        resp_o.tag    = meta_i.tag;
        // Word results always sign-extend bit 31, unsigned forms too
        resp_o.result = meta_i.is_word ? {{WLEN{res[WLEN-1]}}, res[WLEN-1:0]} : res;
    end

endmodule

`default_nettype wire

// File: src/div_unit.sv
// Top of the pipelined M-extension divider; instantiate this in the execution stage
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               kill_i,
    input  div_pkg::div_req_t  req_i,
    output logic               ready_o,
    output div_pkg::div_resp_t resp_o
);

    div_pkg::div_data_t prep_data;
    div_pkg::div_meta_t prep_meta;
    div_pkg::div_data_t w_data;
    div_pkg::div_data_t d_data;
    div_pkg::div_meta_t exit_meta;
    logic               exit_w;

    div_operand_prep u_prep (
        .req_i  (req_i),
        .data_o (prep_data),
        .meta_o (prep_meta)
    );

    // --------------------
    // Datapath and control run in lockstep
    div_array #(
        .N_STAGES (div_pkg::N_STAGES),
        .W_EXIT   (div_pkg::W_EXIT)
    ) u_array (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .data_i   (prep_data),
        .w_data_o (w_data),
        .d_data_o (d_data)
    );

    div_ctrl #(
        .N_STAGES (div_pkg::N_STAGES),
        .W_EXIT   (div_pkg::W_EXIT)
    ) u_ctrl (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .req_valid_i (req_i.valid),
        .req_word_i  (prep_meta.is_word),
        .meta_i      (prep_meta),
        .ready_o     (ready_o),
        .exit_w_o    (exit_w),
        .meta_o      (exit_meta)
    );

    div_result_fix u_fix (
        .meta_i   (exit_meta),
        .exit_w_i (exit_w),
        .w_data_i (w_data),
        .d_data_i (d_data),
        .resp_o   (resp_o)
    );

endmodule

`default_nettype wire

// File: dv/div_unit_assert.sv
// Protocol assertions on the divider control pipeline; bound into every div_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module div_unit_assert (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               kill_i,
    input logic               exit_w_i,
    input div_pkg::div_meta_t d_meta_i,
    input div_pkg::div_meta_t out_meta_i
);

    int fail_cnt = 0;

    a_one_exit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(exit_w_i && d_meta_i.valid && !d_meta_i.is_word))
        else begin
            $error("Word and 64-bit results exit in the same cycle");
            fail_cnt++;
        end

    // Kill empties the whole pipeline
    a_kill_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        kill_i |=> !out_meta_i.valid)
        else begin
            $error("Response valid in the cycle after kill");
            fail_cnt++;
        end

endmodule

bind div_ctrl div_unit_assert u_assert (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .kill_i     (kill_i),
    .exit_w_i   (exit_w_o),
    .d_meta_i   (meta_q[0]),
    .out_meta_i (meta_o)
);

`default_nettype wire

// File: dv/div_checker.sv
// Scoreboard for the divide unit; watches its ports, models each accepted request, compares results
`timescale 1ns/1ps
`default_nettype none

module div_checker (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               kill_i,
    input  logic               ready_i,
    input  div_pkg::div_req_t  req_i,
    input  div_pkg::div_resp_t resp_i,
    output int                 err_cnt_o,
    output int                 pending_o
);

    localparam int          N_TAGS = 1 << div_pkg::TAG_W;
    localparam int          W_LAT  = div_pkg::W_EXIT + 1;     // Acceptance edge to sampling edge
    localparam int          D_LAT  = div_pkg::N_STAGES + 1;
    localparam logic [63:0] MIN64  = 64'h8000_0000_0000_0000;

    logic        pend_v[N_TAGS] = '{default: 1'b0};
    logic        pend_w[N_TAGS];
    logic [63:0] pend_exp[N_TAGS];
    int          pend_due[N_TAGS];   // Edge that samples the response
    int          cyc = 0;
    int          errs = 0;
    int          pending = 0;
    int          n_acc = 0;
    int          n_resp = 0;
    int          n_kill = 0;
    int          n_refused = 0;

    assign err_cnt_o = errs;
    assign pending_o = pending;

    // --------------------
    // RISC-V M-extension result for op code bits word, remainder and unsigned (2 down to 0)
    function automatic logic [63:0] model_result(logic [2:0] code, logic [63:0] a, logic [63:0] b);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] q;
        logic [63:0] r;
        // Word operands extend as 32-bit values
        x = !code[2] ? a : code[0] ? {32'h0, a[31:0]} : {{32{a[31]}}, a[31:0]};
        y = !code[2] ? b : code[0] ? {32'h0, b[31:0]} : {{32{b[31]}}, b[31:0]};
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (code[0]) begin
            q = x / y;
            r = x % y;
        end else if (x == MIN64 && y == '1) begin
            q = x;   // Signed overflow
            r = '0;
        end else begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end
        q = code[1] ? r : q;
        return code[2] ? {{32{q[31]}}, q[31:0]} : q;
    endfunction

    // --------------------
    // Sample at the rising edge after the inputs settled on the falling edge
    always @(posedge clk_i) begin
        logic       clash;
        logic       is_w;
        logic [2:0] code;
        logic [7:0] t;
        cyc++;
        if (rstn_i) begin
            code = req_i.op;
            is_w = code[2];
            if (resp_i.valid) begin
                t = resp_i.tag;
                if (!pend_v[t]) begin
                    $display("Unexpected response for tag %0d at %0t", t, $time);
                    errs++;
                end else begin
                    if (pend_due[t] != cyc) begin
                        $display("ERR %0t resp_o.valid cycle tag %0d: expected %0d, actual %0d",
                                 $time, t, pend_due[t], cyc);
                        errs++;
                    end
                    if (resp_i.result !== pend_exp[t]) begin
                        $display("ERR %0t resp_o.result tag %0d: expected %h, actual %h",
                                 $time, t, pend_exp[t], resp_i.result);
                        errs++;
                    end
                    pend_v[t] = 1'b0;
                    pending--;
                    n_resp++;
                end
            end
            clash = 1'b0;
            for (int i = 0; i < N_TAGS; i++) begin
                // A word op taken now would exit together with this 64-bit op
                clash |= pend_v[i] && !pend_w[i] && pend_due[i] == cyc + W_LAT;
                if (pend_v[i] && pend_due[i] <= cyc) begin
                    $display("Missing response for tag %0d, due at cycle %0d", i, pend_due[i]);
                    errs++;
                end
                if (pend_v[i] && (kill_i || pend_due[i] <= cyc)) begin
                    pend_v[i] = 1'b0;
                    pending--;
                end
            end
            if (ready_i !== !(is_w && clash)) begin
                $display("ERR %0t ready_o: expected %0b, actual %0b",
                         $time, !(is_w && clash), ready_i);
                errs++;
            end
            n_kill += kill_i ? 1 : 0;
            if (req_i.valid && ready_i && !kill_i) begin
                t = req_i.tag;
                pend_v[t]   = 1'b1;
                pend_w[t]   = is_w;
                pend_exp[t] = model_result(code, req_i.src1, req_i.src2);
                pend_due[t] = cyc + (is_w ? W_LAT : D_LAT);
                pending++;
                n_acc++;
            end else if (req_i.valid && !kill_i) begin
                n_refused++;
            end
        end
    end

    task automatic print_summary(input int assert_fails);
        $display("Summary: %0d accepted, %0d answered, %0d refused, %0d kills, %0d errors, %0d %s",
                 n_acc, n_resp, n_refused, n_kill, errs, assert_fails, "assertion failures");
    endtask

endmodule

`default_nettype wire

// File: dv/div_unit_tb.sv
// Testbench top for the divide unit; clock, reset, seeded random requests, kill pulses and timeout
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

    localparam int N_REQ = 1500;
    localparam int LIMIT = N_REQ * 2 + 200;   // Cycle budget for the whole run

    logic               clk_i;
    logic               rstn_i;
    logic               kill_i;
    logic               ready_o;
    logic               took = 1'b0;
    logic               timed_out;
    div_pkg::div_req_t  req;
    div_pkg::div_resp_t resp;
    int                 cyc = 0;
    int                 issued;
    int                 err_cnt;
    int                 pending;
    int                 assert_fails;

    div_unit dut (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .kill_i  (kill_i),
        .req_i   (req),
        .ready_o (ready_o),
        .resp_o  (resp)
    );

    div_checker u_checker (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .kill_i    (kill_i),
        .ready_i   (ready_o),
        .req_i     (req),
        .resp_i    (resp),
        .err_cnt_o (err_cnt),
        .pending_o (pending)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc  <= cyc + 1;
        took <= req.valid && ready_o && !kill_i;   // Request taken at this edge
    end

    // Operands biased toward the divide corner cases
    function automatic logic [63:0] pick_operand();
        case ($urandom_range(0, 8))
            0: return '0;
            1: return '1;
            2: return 64'h8000_0000_0000_0000;
            3: return {$urandom(), 32'h8000_0000};   // Most negative word
            4: return {$urandom(), 32'hFFFF_FFFF};   // Word minus one
            5: return {$urandom(), 32'h0};           // Zero word, upper half set
            6: return 64'($urandom_range(1, 15));
            7: return -64'($urandom_range(1, 15));
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    initial begin
        void'($urandom(32'h90283c80));
        rstn_i = 1'b0;
        kill_i = 1'b0;
        req    = '0;
        issued = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // --------------------
        // Each request stays valid until the DUT takes it
        while (issued < N_REQ && cyc < LIMIT) begin
            @(negedge clk_i);
            if (took) begin
                issued++;
                req.valid = 1'b0;
            end
            kill_i = ($urandom_range(0, 249) == 0);
            if (!req.valid && issued < N_REQ && $urandom_range(0, 99) < 85) begin
                req.valid = 1'b1;
                req.op    = div_pkg::div_op_e'(3'($urandom_range(0, 7)));
                req.tag   = req.tag + 8'd1;
                req.src1  = pick_operand();
                req.src2  = pick_operand();
            end
        end
        kill_i    = 1'b0;
        req.valid = 1'b0;
        while (pending != 0 && cyc < LIMIT) begin
            @(negedge clk_i);
        end
        timed_out = (cyc >= LIMIT);
        repeat (40) @(negedge clk_i);   // Catch stray responses

        // --------------------
        assert_fails = dut.u_ctrl.u_assert.fail_cnt;
        if (timed_out) begin
            $display("Timeout: %0d of %0d requests accepted, %0d still in flight after %0d cycles",
                     issued, N_REQ, pending, cyc);
        end
        u_checker.print_summary(assert_fails);
        if (!timed_out && err_cnt == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: div_unit.f
src/div_pkg.sv
src/div_operand_prep.sv
src/div_stage.sv
src/div_array.sv
src/div_ctrl.sv
src/div_result_fix.sv
src/div_unit.sv
dv/div_unit_assert.sv
dv/div_checker.sv
dv/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module div_unit_tb -Mdir obj_dir -f div_unit.f
status=0
./obj_dir/Vdiv_unit_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Verification failed" sim.log; then
    echo "FAIL: see sim.log"
    exit 1
fi
echo "PASS"
